// File: hw/cpu_cfg_pkg.sv
/* cpu configuration package.
   datapath widths and tag constants used by the multiply unit. */
package cpu_cfg_pkg;

	// integer datapath width.
	localparam int XLEN = 64;

	// rob index width, ports carry one extra wrap bit.
	localparam int ROB_IDX_W = 5;

	localparam int PRF_IDX_W = 6; // physical register tag.

	localparam int BR_MASK_W = 4; // one bit per outstanding branch.

	// hard-wired zero register, also marks an empty slot.
	localparam logic [PRF_IDX_W-1:0] ZERO_REG = '1;

endpackage

// File: hw/mult_ctrl.sv
/* multiply pipeline controller.
   tracks valid, opcode, rob index, tag and branch mask per slot, with stall and squash. */
`timescale 1ns/1ps

module mult_ctrl #(
	parameter int NUM_STAGES = 4
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              start_i,
	input  mult_isa_pkg::mult_op_e            op_i,
	input  logic [cpu_cfg_pkg::ROB_IDX_W:0]   rob_idx_i,
	input  logic [cpu_cfg_pkg::PRF_IDX_W-1:0] dest_tag_i,
	input  logic [cpu_cfg_pkg::BR_MASK_W-1:0] br_mask_i,
	input  logic                              rob_br_recovery_i,
	input  logic                              rob_br_pred_correct_i,
	input  logic [cpu_cfg_pkg::BR_MASK_W-1:0] rob_br_tag_fix_i,
	input  logic                              stall_i,
	output logic                              advance_o,
	output logic                              wb_load_o,
	output mult_isa_pkg::mult_op_e            wb_op_o,
	output logic                              done_pre_o,
	output logic                              done_o,
	output logic [cpu_cfg_pkg::ROB_IDX_W:0]   rob_idx_o,
	output logic [cpu_cfg_pkg::PRF_IDX_W-1:0] dest_tag_o,
	output logic [cpu_cfg_pkg::BR_MASK_W-1:0] br_mask_o
);

	import cpu_cfg_pkg::*;
	import mult_isa_pkg::*;

	// one slot per stage plus the writeback slot at the end.
	localparam int NUM_SLOTS = NUM_STAGES + 1;

	logic                 advance;
	logic [BR_MASK_W-1:0] keep_bits;
	logic [NUM_SLOTS-1:0] squash;

	logic [NUM_SLOTS-1:0] valid_q;
	logic [NUM_SLOTS-1:0] valid_d;
	logic [ROB_IDX_W:0]   rob_idx_q [NUM_SLOTS];
	logic [ROB_IDX_W:0]   rob_idx_d [NUM_SLOTS];
	logic [PRF_IDX_W-1:0] tag_q [NUM_SLOTS];
	logic [PRF_IDX_W-1:0] tag_d [NUM_SLOTS];
	logic [BR_MASK_W-1:0] mask_q [NUM_SLOTS];
	logic [BR_MASK_W-1:0] mask_d [NUM_SLOTS];

	// the writeback slot needs no opcode, sign extension happens on its way in.
	mult_op_e op_q [NUM_STAGES];
	mult_op_e op_d [NUM_STAGES];

	assign advance = ~stall_i & ~rob_br_recovery_i;

	// a resolved branch drops out of every mask that moves this cycle.
	assign keep_bits = rob_br_pred_correct_i ? ~rob_br_tag_fix_i : '1;

	always_comb begin
		for (int j = 0; j < NUM_SLOTS; j++) begin
			squash[j] = rob_br_recovery_i && ((mask_q[j] & rob_br_tag_fix_i) != '0);
		end
	end

	// each slot takes from the one before it, slot 0 from the issue port.
	always_comb begin
		valid_d[0] = start_i;
		rob_idx_d[0] = rob_idx_i;
		tag_d[0] = dest_tag_i;
		mask_d[0] = br_mask_i & keep_bits;
		op_d[0] = op_i;
		for (int j = 1; j < NUM_SLOTS; j++) begin
			valid_d[j] = valid_q[j-1];
			rob_idx_d[j] = rob_idx_q[j-1];
			tag_d[j] = tag_q[j-1];
			mask_d[j] = mask_q[j-1] & keep_bits;
		end
		for (int j = 1; j < NUM_STAGES; j++) begin
			op_d[j] = op_q[j-1];
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < NUM_SLOTS; j++) begin
			if (rst || squash[j]) begin
				valid_q[j] <= 1'b0;
				rob_idx_q[j] <= '0;
				tag_q[j] <= ZERO_REG;
				mask_q[j] <= '0;
			end else if (advance) begin
				valid_q[j] <= valid_d[j];
				rob_idx_q[j] <= rob_idx_d[j];
				tag_q[j] <= tag_d[j];
				mask_q[j] <= mask_d[j];
			end
		end
		for (int j = 0; j < NUM_STAGES; j++) begin
			if (rst) begin
				op_q[j] <= op_mulq;
			end else if (advance) begin
				op_q[j] <= op_d[j];
			end
		end
	end

	assign advance_o = advance;
	assign wb_load_o = advance; // writeback register moves with the slots.
	assign wb_op_o = op_q[NUM_STAGES-1];

	assign done_pre_o = valid_q[NUM_STAGES-1]; // last stage, one cycle early.
	assign done_o = valid_q[NUM_STAGES];
	assign rob_idx_o = rob_idx_q[NUM_STAGES];
	assign dest_tag_o = tag_q[NUM_STAGES];
	assign br_mask_o = mask_q[NUM_STAGES];

endmodule

// File: hw/mult_isa_pkg.sv
/* multiply ISA package.
   opcode encoding and instruction field positions for integer multiply. */
package mult_isa_pkg;

	// longword keeps 32 bits and sign-extends, quadword keeps 64.
	typedef enum logic {
		op_mull = 1'b0,
		op_mulq = 1'b1
	} mult_op_e;

	// literal form of the second operand.
	localparam int LIT_FLAG_BIT = 12;
	localparam int LIT_LSB = 13;
	localparam int LIT_MSB = 20;

	// function field of an operate-format instruction.
	localparam int FUNC_LSB = 5;
	localparam int FUNC_MSB = 11;

	localparam logic [FUNC_MSB-FUNC_LSB:0] FUNC_MULL = 7'h00; // anything else is mulq.

endpackage

// File: hw/mult_operand_sel.sv
/* multiply operand select.
   decodes the opcode and picks register or literal as the multiplier. */
`timescale 1ns/1ps

module mult_operand_sel (
	input  logic [cpu_cfg_pkg::XLEN-1:0] opa_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] opb_i,
	input  logic [31:0]                  inst_i,
	output logic [cpu_cfg_pkg::XLEN-1:0] mcand_o,
	output logic [cpu_cfg_pkg::XLEN-1:0] mplier_o,
	output mult_isa_pkg::mult_op_e       op_o
);

	import cpu_cfg_pkg::*;
	import mult_isa_pkg::*;

	localparam int LIT_W = LIT_MSB - LIT_LSB + 1;
	localparam int FUNC_W = FUNC_MSB - FUNC_LSB + 1;

	logic [LIT_W-1:0]  lit;
	logic [XLEN-1:0]   lit_ext;
	logic [FUNC_W-1:0] func;
	logic              use_lit;

	assign lit = inst_i[LIT_MSB:LIT_LSB];
	assign func = inst_i[FUNC_MSB:FUNC_LSB];
	assign use_lit = inst_i[LIT_FLAG_BIT];

	// literal is unsigned.
	assign lit_ext = {{(XLEN-LIT_W){1'b0}}, lit};

	assign mcand_o = opa_i;
	assign mplier_o = use_lit ? lit_ext : opb_i;

	// only one function code selects the longword form.
	always_comb begin
		if (func == FUNC_MULL) begin
			op_o = op_mull;
		end else begin
			op_o = op_mulq;
		end
	end

endmodule

// File: hw/mult_stage.sv
/* multiplier pipeline stage.
   adds one slice of partial product and shifts the operands for the next slice. */
`timescale 1ns/1ps

module mult_stage #(
	parameter int BITS_PER_STAGE = 16
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         advance_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] product_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] mplier_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] mcand_i,
	output logic [cpu_cfg_pkg::XLEN-1:0] product_o,
	output logic [cpu_cfg_pkg::XLEN-1:0] mplier_o,
	output logic [cpu_cfg_pkg::XLEN-1:0] mcand_o
);

	import cpu_cfg_pkg::*;

	logic [XLEN-1:0] partial_prod;
	logic [XLEN-1:0] next_mplier;
	logic [XLEN-1:0] next_mcand;
	logic [XLEN-1:0] prod_in_q;
	logic [XLEN-1:0] partial_q;

	// low slice of the multiplier times the full multiplicand, truncated.
	assign partial_prod = mplier_i[BITS_PER_STAGE-1:0] * mcand_i;

	assign next_mplier = mplier_i >> BITS_PER_STAGE; // consumed bits drop out.
	assign next_mcand = mcand_i << BITS_PER_STAGE;   // keeps the slice weight aligned.

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_in_q <= '0;
			partial_q <= '0;
			mplier_o <= '0;
			mcand_o <= '0;
		end else if (advance_i) begin
			prod_in_q <= product_i;
			partial_q <= partial_prod;
			mplier_o <= next_mplier;
			mcand_o <= next_mcand;
		end
	end

	// the add sits after the register, so the multiply and add split across cycles.
	assign product_o = prod_in_q + partial_q;

endmodule

// File: hw/mult_unit.sv
/* pipelined integer multiply unit.
   operand select, partial-product stages, slot controller and writeback register. */
`timescale 1ns/1ps

module mult_unit #(
	parameter int NUM_STAGES = 4
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [cpu_cfg_pkg::XLEN-1:0]      opa_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0]      opb_i,
	input  logic                              start_i,
	input  logic [31:0]                       inst_i,
	input  logic [cpu_cfg_pkg::ROB_IDX_W:0]   rob_idx_i,
	input  logic [cpu_cfg_pkg::PRF_IDX_W-1:0] dest_tag_i,
	input  logic [cpu_cfg_pkg::BR_MASK_W-1:0] br_mask_i,
	input  logic                              rob_br_recovery_i,
	input  logic                              rob_br_pred_correct_i,
	input  logic [cpu_cfg_pkg::BR_MASK_W-1:0] rob_br_tag_fix_i,
	input  logic                              stall_i,
	output logic [cpu_cfg_pkg::XLEN-1:0]      product_o,
	output logic [cpu_cfg_pkg::ROB_IDX_W:0]   rob_idx_o,
	output logic [cpu_cfg_pkg::PRF_IDX_W-1:0] dest_tag_o,
	output logic [cpu_cfg_pkg::BR_MASK_W-1:0] br_mask_o,
	output logic                              done_pre_o,
	output logic                              done_o
);

	import cpu_cfg_pkg::*;
	import mult_isa_pkg::*;

	localparam int BITS_PER_STAGE = XLEN / NUM_STAGES;

	mult_op_e issue_op;
	mult_op_e wb_op;
	logic     advance;
	logic     wb_load;

	// index k is the input of stage k, index NUM_STAGES the last stage output.
	logic [XLEN-1:0] product_w [NUM_STAGES+1];
	logic [XLEN-1:0] mplier_w [NUM_STAGES+1];
	logic [XLEN-1:0] mcand_w [NUM_STAGES+1];

	assign product_w[0] = '0; // running sum starts empty.

	mult_operand_sel mult_operand_sel_inst (
		.opa_i    (opa_i),
		.opb_i    (opb_i),
		.inst_i   (inst_i),
		.mcand_o  (mcand_w[0]),
		.mplier_o (mplier_w[0]),
		.op_o     (issue_op)
	);

	mult_ctrl #(
		.NUM_STAGES (NUM_STAGES)
	) mult_ctrl_inst (
		.clk                   (clk),
		.rst                   (rst),
		.start_i               (start_i),
		.op_i                  (issue_op),
		.rob_idx_i             (rob_idx_i),
		.dest_tag_i            (dest_tag_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.stall_i               (stall_i),
		.advance_o             (advance),
		.wb_load_o             (wb_load),
		.wb_op_o               (wb_op),
		.done_pre_o            (done_pre_o),
		.done_o                (done_o),
		.rob_idx_o             (rob_idx_o),
		.dest_tag_o            (dest_tag_o),
		.br_mask_o             (br_mask_o)
	);

	for (genvar k = 0; k < NUM_STAGES; k++) begin : gen_stage
		mult_stage #(
			.BITS_PER_STAGE (BITS_PER_STAGE)
		) mult_stage_inst (
			.clk       (clk),
			.rst       (rst),
			.advance_i (advance),
			.product_i (product_w[k]),
			.mplier_i  (mplier_w[k]),
			.mcand_i   (mcand_w[k]),
			.product_o (product_w[k+1]),
			.mplier_o  (mplier_w[k+1]),
			.mcand_o   (mcand_w[k+1])
		);
	end

	mult_writeback mult_writeback_inst (
		.clk       (clk),
		.rst       (rst),
		.load_i    (wb_load),
		.op_i      (wb_op),
		.product_i (product_w[NUM_STAGES]),
		.product_o (product_o)
	);

endmodule

// File: hw/mult_writeback.sv
/* multiply writeback register.
   holds the final product, sign-extending longword results. */
`timescale 1ns/1ps

module mult_writeback (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         load_i,
	input  mult_isa_pkg::mult_op_e       op_i,
	input  logic [cpu_cfg_pkg::XLEN-1:0] product_i,
	output logic [cpu_cfg_pkg::XLEN-1:0] product_o
);

	import cpu_cfg_pkg::*;
	import mult_isa_pkg::*;

	localparam int WORD_W = 32; // longword width.

	logic [XLEN-1:0] result;

	always_comb begin
		result = product_i;
		if (op_i == op_mull) begin
			result[XLEN-1:WORD_W] = {(XLEN-WORD_W){product_i[WORD_W-1]}}; // sign-extend.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			product_o <= '0;
		end else if (load_i) begin
			product_o <= result;
		end
	end

endmodule

// File: project.f
hw/cpu_cfg_pkg.sv
hw/mult_isa_pkg.sv
hw/mult_operand_sel.sv
hw/mult_stage.sv
hw/mult_ctrl.sv
hw/mult_writeback.sv
hw/mult_unit.sv
test/mult_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the multiply unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module mult_unit_tb \
	-f project.f -o sim_mult_unit
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_mult_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: test/mult_unit_tb.sv
/* multiply unit testbench.
   directed tests checked against a queue-based reference model. */
`timescale 1ns/1ps

module mult_unit_tb;

	import cpu_cfg_pkg::*;
	import mult_isa_pkg::*;

	localparam int NUM_STAGES = 4;
	localparam int LATENCY = NUM_STAGES + 1;  // cycles from driving start_i to done_o.
	localparam int TIMEOUT_CYCLES = 4000;     // all tests together take a few hundred.
	localparam int DRAIN_LIMIT = 64;

	typedef logic [ROB_IDX_W:0] rob_idx_t;
	typedef logic [PRF_IDX_W-1:0] tag_t;
	typedef logic [BR_MASK_W-1:0] mask_t;
	typedef logic [FUNC_MSB-FUNC_LSB:0] func_t;

	// masks of the five ops in flight when a branch resolves.
	localparam mask_t BURST_MASKS [5] = '{4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b0110};
	localparam mask_t FIX_TAG = 4'b0010;

	logic            clk;
	logic            rst;
	logic [XLEN-1:0] opa_i;
	logic [XLEN-1:0] opb_i;
	logic            start_i;
	logic [31:0]     inst_i;
	rob_idx_t        rob_idx_i;
	tag_t            dest_tag_i;
	mask_t           br_mask_i;
	logic            rob_br_recovery_i;
	logic            rob_br_pred_correct_i;
	mask_t           rob_br_tag_fix_i;
	logic            stall_i;
	logic [XLEN-1:0] product_o;
	rob_idx_t        rob_idx_o;
	tag_t            dest_tag_o;
	mask_t           br_mask_o;
	logic            done_pre_o;
	logic            done_o;

	// expected results in issue order.
	logic [XLEN-1:0] exp_prod [$];
	rob_idx_t        exp_rob [$];
	tag_t            exp_tag [$];
	mask_t           exp_mask [$];

	logic [31:0]     lfsr_state = 32'h8b6d;
	int              cycle_count = 0;
	logic            prev_done;
	logic [XLEN-1:0] prev_product;
	rob_idx_t        prev_rob;
	tag_t            prev_tag;

	mult_unit #(
		.NUM_STAGES (NUM_STAGES)
	) mult_unit_inst (
		.clk                   (clk),
		.rst                   (rst),
		.opa_i                 (opa_i),
		.opb_i                 (opb_i),
		.start_i               (start_i),
		.inst_i                (inst_i),
		.rob_idx_i             (rob_idx_i),
		.dest_tag_i            (dest_tag_i),
		.br_mask_i             (br_mask_i),
		.rob_br_recovery_i     (rob_br_recovery_i),
		.rob_br_pred_correct_i (rob_br_pred_correct_i),
		.rob_br_tag_fix_i      (rob_br_tag_fix_i),
		.stall_i               (stall_i),
		.product_o             (product_o),
		.rob_idx_o             (rob_idx_o),
		.dest_tag_o            (dest_tag_o),
		.br_mask_o             (br_mask_o),
		.done_pre_o            (done_pre_o),
		.done_o                (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[62:0], lfsr_state[0]};
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t ns: %s = %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// full 128-bit product truncated per opcode.
	function automatic logic [XLEN-1:0] expected_product(input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [31:0] inst);
		logic [XLEN-1:0]   mplier;
		logic [2*XLEN-1:0] full;
		mplier = inst[LIT_FLAG_BIT] ? {{(XLEN-8){1'b0}}, inst[LIT_MSB:LIT_LSB]} : b;
		full = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, mplier};
		if (inst[FUNC_MSB:FUNC_LSB] == FUNC_MULL) begin
			return {{32{full[31]}}, full[31:0]};
		end
		return full[XLEN-1:0];
	endfunction

	function automatic func_t quad_func();
		func_t f;
		f = func_t'(rand_bits(7));
		if (f == FUNC_MULL) begin
			f = func_t'(1); // any nonzero code is mulq.
		end
		return f;
	endfunction

	function automatic logic [31:0] make_inst(input func_t func, input logic lit_flag,
			input logic [7:0] lit);
		logic [31:0] inst;
		inst = 32'(rand_bits(32)); // unrelated fields stay random.
		inst[FUNC_MSB:FUNC_LSB] = func;
		inst[LIT_FLAG_BIT] = lit_flag;
		inst[LIT_MSB:LIT_LSB] = lit;
		return inst;
	endfunction

	// applies what the pipe does at this edge to the model.
	task automatic model_edge();
		mask_t keep;
		keep = rob_br_pred_correct_i ? ~rob_br_tag_fix_i : '1;
		if (rob_br_recovery_i) begin
			for (int i = exp_prod.size() - 1; i >= 0; i--) begin
				if ((exp_mask[i] & rob_br_tag_fix_i) != '0) begin
					exp_prod.delete(i);
					exp_rob.delete(i);
					exp_tag.delete(i);
					exp_mask.delete(i);
				end
			end
		end else if (!stall_i) begin
			for (int i = 0; i < exp_mask.size(); i++) begin
				exp_mask[i] = exp_mask[i] & keep;
			end
			if (start_i) begin
				exp_prod.push_back(expected_product(opa_i, opb_i, inst_i));
				exp_rob.push_back(rob_idx_i);
				exp_tag.push_back(dest_tag_i);
				exp_mask.push_back(br_mask_i & keep);
			end
		end
	endtask

	task automatic check_outputs(input logic adv, input logic stalled);
		if (stalled) begin
			check_value("done_o (stalled)", 64'(done_o), 64'(prev_done));
			check_value("product_o (stalled)", product_o, prev_product);
			check_value("rob_idx_o (stalled)", 64'(rob_idx_o), 64'(prev_rob));
			check_value("dest_tag_o (stalled)", 64'(dest_tag_o), 64'(prev_tag));
		end else if (adv && done_o) begin
			if (exp_prod.size() == 0) begin
				report_failure("done_o went high with no operation pending in the model");
			end else begin
				check_value("product_o", product_o, exp_prod.pop_front());
				check_value("rob_idx_o", 64'(rob_idx_o), 64'(exp_rob.pop_front()));
				check_value("dest_tag_o", 64'(dest_tag_o), 64'(exp_tag.pop_front()));
				check_value("br_mask_o", 64'(br_mask_o), 64'(exp_mask.pop_front()));
			end
		end
		prev_done = done_o;
		prev_product = product_o;
		prev_rob = rob_idx_o;
		prev_tag = dest_tag_o;
	endtask

	// model steps at the edge and outputs are compared half a cycle later.
	initial begin : monitor
		logic adv;
		logic stalled;
		logic in_reset;
		forever begin
			@(posedge clk);
			in_reset = rst;
			adv = !stall_i && !rob_br_recovery_i;
			stalled = stall_i && !rob_br_recovery_i;
			if (!in_reset) begin
				model_edge();
			end
			@(negedge clk);
			if (!in_reset) begin
				check_outputs(adv, stalled);
			end
		end
	end

	initial begin : watchdog
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				report_failure("timeout: the tests did not finish within the cycle limit");
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_issue(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
			input logic [31:0] inst, input rob_idx_t rob, input tag_t tag, input mask_t mask);
		opa_i = a;
		opb_i = b;
		inst_i = inst;
		rob_idx_i = rob;
		dest_tag_i = tag;
		br_mask_i = mask;
		start_i = 1'b1;
		next_cycle();
		start_i = 1'b0;
	endtask

	task automatic issue_random(input rob_idx_t rob, input mask_t mask);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		func_t           func;
		logic [31:0]     inst;
		a = rand_bits(64);
		b = rand_bits(64);
		func = (rand_bits(1) == 64'd1) ? FUNC_MULL : quad_func();
		inst = make_inst(func, rand_bits(1) == 64'd1, 8'(rand_bits(8)));
		drive_issue(a, b, inst, rob, tag_t'(rand_bits(PRF_IDX_W)), mask);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_prod.size() != 0 && n < DRAIN_LIMIT) begin
			next_cycle();
			n++;
		end
		if (exp_prod.size() != 0) begin
			report_failure("expected results never came out of the pipeline");
		end
		repeat (LATENCY) next_cycle(); // lets a stray result show up.
	endtask

	task automatic check_reset_state();
		check_value("done_o", 64'(done_o), 64'(0));
		check_value("done_pre_o", 64'(done_pre_o), 64'(0));
		check_value("dest_tag_o", 64'(dest_tag_o), 64'(ZERO_REG));
		check_value("br_mask_o", 64'(br_mask_o), 64'(0));
		check_value("product_o", product_o, 64'(0));
	endtask

	task automatic single_quadword();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = rand_bits(64);
		b = rand_bits(64);
		drive_issue(a, b, make_inst(quad_func(), 1'b0, 8'h00), rob_idx_t'(5), tag_t'(17), '0);
		for (int cyc = 1; cyc <= LATENCY + 1; cyc++) begin
			if (cyc > 1) begin
				next_cycle();
			end
			check_value("done_pre_o", 64'(done_pre_o), 64'(cyc == LATENCY - 1));
			check_value("done_o", 64'(done_o), 64'(cyc == LATENCY));
		end
		wait_drain();
	endtask

	task automatic literal_and_longword();
		drive_issue(rand_bits(64), rand_bits(64), make_inst(quad_func(), 1'b1, 8'(rand_bits(8))),
			rob_idx_t'(1), tag_t'(3), '0);
		drive_issue(rand_bits(64), rand_bits(64), make_inst(FUNC_MULL, 1'b1, 8'(rand_bits(8))),
			rob_idx_t'(2), tag_t'(4), '0);
		// bit 31 set and then clear with junk in the upper word.
		drive_issue(64'hdead_beef_8000_0003, 64'h1, make_inst(FUNC_MULL, 1'b0, 8'h00),
			rob_idx_t'(3), tag_t'(5), '0);
		drive_issue(64'hffff_ffff_7fff_fff1, 64'h1, make_inst(FUNC_MULL, 1'b0, 8'h00),
			rob_idx_t'(4), tag_t'(6), '0);
		drive_issue(rand_bits(64), rand_bits(64), make_inst(FUNC_MULL, 1'b0, 8'h00),
			rob_idx_t'(5), tag_t'(7), '0);
		wait_drain();
	endtask

	task automatic back_to_back_stalls();
		int gap;
		for (int i = 0; i < 20; i++) begin
			if (rand_bits(1) == 64'd1) begin
				gap = int'(rand_bits(2)) + 1;
				stall_i = 1'b1;
				repeat (gap) next_cycle();
				stall_i = 1'b0;
			end
			issue_random(rob_idx_t'(i), '0);
		end
		wait_drain();
	endtask

	task automatic issue_mask_burst();
		for (int i = 0; i < 5; i++) begin
			issue_random(rob_idx_t'(10 + i), BURST_MASKS[i]);
		end
	endtask

	task automatic branch_squash();
		issue_mask_burst();
		rob_br_tag_fix_i = FIX_TAG;
		rob_br_recovery_i = 1'b1;
		next_cycle();
		rob_br_recovery_i = 1'b0;
		rob_br_tag_fix_i = '0;
		wait_drain();
	endtask

	task automatic branch_resolve();
		issue_mask_burst();
		rob_br_tag_fix_i = FIX_TAG;
		rob_br_pred_correct_i = 1'b1;
		next_cycle();
		rob_br_pred_correct_i = 1'b0;
		rob_br_tag_fix_i = '0;
		wait_drain();
	endtask

	initial begin
		rst = 1'b1;
		opa_i = '0;
		opb_i = '0;
		start_i = 1'b0;
		inst_i = '0;
		rob_idx_i = '0;
		dest_tag_i = '0;
		br_mask_i = '0;
		rob_br_recovery_i = 1'b0;
		rob_br_pred_correct_i = 1'b0;
		rob_br_tag_fix_i = '0;
		stall_i = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		check_reset_state();
		single_quadword();
		literal_and_longword();
		back_to_back_stalls();
		branch_squash();
		branch_resolve();
		$display("TEST PASSED");
		$finish;
	end

endmodule
